/* design/uart_reg_pkg.sv */
// UART register map and APB constants
`default_nettype none

package uart_reg_pkg;

  // APB slave port, one 4KB window
  localparam int APB_ADDR_WIDTH = 12;
  localparam int APB_DATA_WIDTH = 32;

  // register offsets, word index from PADDR[2:0]
  localparam logic [2:0] REG_RBR_THR_DLL = 3'h0;  // DLL when DLAB set
  localparam logic [2:0] REG_IER_DLM     = 3'h1;  // DLM when DLAB set
  localparam logic [2:0] REG_IIR_FCR     = 3'h2;  // IIR on read, FCR on write
  localparam logic [2:0] REG_LCR         = 3'h3;
  localparam logic [2:0] REG_LSR         = 3'h5;
  localparam logic [2:0] REG_SCR         = 3'h7;
  // offsets 4 and 6 (modem regs) read as zero

  // line status bit positions
  localparam int LSR_DR   = 0;  // rx data ready
  localparam int LSR_PE   = 2;  // parity error on head entry
  localparam int LSR_THRE = 5;  // tx fifo empty
  localparam int LSR_TEMT = 6;  // tx fifo and shifter empty

  // interrupt identification codes, low nibble of IIR
  localparam logic [3:0] IIR_NONE = 4'b0001;  // nothing pending
  localparam logic [3:0] IIR_RLS  = 4'b0110;  // line status, highest
  localparam logic [3:0] IIR_RDA  = 4'b0100;  // rx data available
  localparam logic [3:0] IIR_THRE = 4'b0010;  // tx holding empty, lowest

  // LSR value out of reset
  localparam logic [7:0] LSR_RESET = 8'h60;

endpackage

`default_nettype wire

/* design/uart_line_pkg.sv */
// UART serial line and payload types
`default_nettype none

package uart_line_pkg;

  // fifo sizes, entries
  localparam int TX_FIFO_DEPTH = 16;
  localparam int RX_FIFO_DEPTH = 16;

  // one character on the line
  typedef logic [7:0] uart_byte_t;

  // rx fifo entry, flag in bit 8
  typedef struct packed {
    logic       parity_err;
    uart_byte_t data;
  } uart_rx_word_t;

  typedef logic [15:0] div_t;  // bit period minus one

  // LCR[1:0] character length
  typedef logic [1:0] char_len_t;
  localparam char_len_t CHAR_LEN_5 = 2'd0;
  localparam char_len_t CHAR_LEN_6 = 2'd1;
  localparam char_len_t CHAR_LEN_7 = 2'd2;
  localparam char_len_t CHAR_LEN_8 = 2'd3;

  typedef logic [1:0] trig_t;  // FCR[7:6], 1/4/8/14 entries

  // fill counts, one bit wider than the pointers
  typedef logic [$clog2(TX_FIFO_DEPTH):0] tx_count_t;
  typedef logic [$clog2(RX_FIFO_DEPTH):0] rx_count_t;

endpackage

`default_nettype wire

/* design/uart_fifo.sv */
// UART first-word fall-through FIFO
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
  parameter int  DEPTH     = 16,
  parameter type payload_t = logic [7:0]
) (
  input  logic                   CLK,
  input  logic                   RSTN,
  input  logic                   clr_i,       // sync flush
  input  logic                   valid_i,     // write side
  input  payload_t               data_i,
  output logic                   ready_o,
  output payload_t               data_o,      // read side, head entry
  output logic                   valid_o,
  input  logic                   ready_i,
  output logic [$clog2(DEPTH):0] elements_o   // fill count
);

  payload_t                 mem [DEPTH];  // storage, no reset
  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(DEPTH):0]   count_q;
  logic                     push;
  logic                     pop;

  assign ready_o    = (count_q != DEPTH);  // full blocks writes
  assign valid_o    = (count_q != '0);
  assign push       = valid_i & ready_o;
  assign pop        = valid_o & ready_i;
  assign data_o     = mem[rd_ptr_q];       // head visible the cycle after push
  assign elements_o = count_q;

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;  // drop everything held
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle, or push and pop together
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/uart_tx.sv */
// UART serial transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_line_pkg::*; (
  input  logic       CLK,
  input  logic       RSTN,
  input  div_t       div_i,        // bit period is div_i + 1 clocks
  input  char_len_t  char_len_i,
  input  logic       parity_en_i,  // even parity when set
  input  logic       two_stop_i,
  input  uart_byte_t data_i,
  input  logic       valid_i,
  output logic       ready_o,      // high only while idle
  output logic       tx_o
);

  typedef enum logic [2:0] {
    TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
  } tx_state_t;

  tx_state_t  state_q;
  div_t       baud_cnt_q;
  logic [2:0] bit_cnt_q;   // data bit index, stop bit index
  logic [2:0] last_bit;
  uart_byte_t shift_q;
  logic       parity_q;    // running xor of data bits
  logic       bit_done;

  assign last_bit = {1'b0, char_len_i} + 3'd4;  // 5..8 bits -> index 4..7
  assign bit_done = (baud_cnt_q == div_i);
  assign ready_o  = (state_q == TX_IDLE);

  // line level straight from the FSM
  always_comb begin
    case (state_q)
      TX_START:  tx_o = 1'b0;
      TX_DATA:   tx_o = shift_q[0];  // lsb first
      TX_PARITY: tx_o = parity_q;
      default:   tx_o = 1'b1;        // idle and stop are mark
    endcase
  end

  // shifter loads on acceptance
  always_ff @(posedge CLK) begin
    if (state_q == TX_IDLE && valid_i) begin
      shift_q <= data_i;
    end else if (state_q == TX_DATA && bit_done) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state_q    <= TX_IDLE;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      parity_q   <= 1'b0;
    end else begin
      baud_cnt_q <= (state_q == TX_IDLE || bit_done) ? '0 : baud_cnt_q + 1'b1;
      case (state_q)
        TX_IDLE: begin
          if (valid_i) begin
            state_q   <= TX_START;  // start bit from next cycle
            bit_cnt_q <= '0;
            parity_q  <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_done) state_q <= TX_DATA;
        end
        TX_DATA: begin
          if (bit_done) begin
            parity_q <= parity_q ^ shift_q[0];
            if (bit_cnt_q == last_bit) begin
              bit_cnt_q <= '0;
              state_q   <= parity_en_i ? TX_PARITY : TX_STOP;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        TX_PARITY: begin
          if (bit_done) state_q <= TX_STOP;
        end
        TX_STOP: begin
          if (bit_done) begin
            if (two_stop_i && bit_cnt_q == '0) begin
              bit_cnt_q <= 3'd1;  // second stop bit
            end else begin
              state_q <= TX_IDLE;
            end
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/uart_rx.sv */
// UART serial receiver
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_line_pkg::*; (
  input  logic          CLK,
  input  logic          RSTN,
  input  logic          rx_i,         // async line
  input  div_t          div_i,
  input  char_len_t     char_len_i,
  input  logic          parity_en_i,
  output uart_rx_word_t rx_word_o,
  output logic          rx_valid_o,
  input  logic          rx_ready_i    // fifo has room
);

  typedef enum logic [2:0] {
    RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP, RX_HOLD
  } rx_state_t;

  rx_state_t     state_q;
  logic [1:0]    sync_q;      // two-flop synchronizer
  logic          rx_prev_q;   // for falling edge detect
  logic          rx_s;
  div_t          baud_cnt_q;
  logic [2:0]    bit_cnt_q;
  logic [2:0]    last_bit;
  uart_byte_t    shift_q;     // bits enter at the top
  uart_byte_t    aligned;
  logic          parity_q;    // running xor
  logic          perr_q;
  logic          half_done;
  logic          bit_done;
  logic          cnt_restart;
  uart_rx_word_t word_q;

  assign rx_s       = sync_q[1];
  assign last_bit   = {1'b0, char_len_i} + 3'd4;
  assign half_done  = (baud_cnt_q == {1'b0, div_i[15:1]});
  assign bit_done   = (baud_cnt_q == div_i);
  assign rx_valid_o = (state_q == RX_HOLD);
  assign rx_word_o  = word_q;

  // counter restarts at mid start bit, then runs whole bit periods
  always_comb begin
    case (state_q)
      RX_IDLE, RX_HOLD: cnt_restart = 1'b1;
      RX_START:         cnt_restart = half_done;
      default:          cnt_restart = bit_done;
    endcase
  end

  // short characters end up in the upper bits, shift them down
  always_comb begin
    case (char_len_i)
      CHAR_LEN_5: aligned = {3'b000, shift_q[7:3]};
      CHAR_LEN_6: aligned = {2'b00, shift_q[7:2]};
      CHAR_LEN_7: aligned = {1'b0, shift_q[7:1]};
      default:    aligned = shift_q;  // 8 bits
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // payload
  always_ff @(posedge CLK) begin
    if (state_q == RX_DATA && bit_done) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
    if (state_q == RX_STOP && bit_done) begin
      word_q.data       <= aligned;
      word_q.parity_err <= perr_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // synchronizer and frame FSM
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      sync_q     <= 2'b11;  // line idles high
      rx_prev_q  <= 1'b1;
      state_q    <= RX_IDLE;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      parity_q   <= 1'b0;
      perr_q     <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], rx_i};
      rx_prev_q  <= rx_s;
      baud_cnt_q <= cnt_restart ? '0 : baud_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          if (rx_prev_q && !rx_s) begin  // falling edge
            state_q   <= RX_START;
            bit_cnt_q <= '0;
            parity_q  <= 1'b0;
            perr_q    <= 1'b0;
          end
        end
        RX_START: begin
          if (half_done) state_q <= rx_s ? RX_IDLE : RX_DATA;  // glitch reject
        end
        RX_DATA: begin
          if (bit_done) begin
            parity_q <= parity_q ^ rx_s;
            if (bit_cnt_q == last_bit) begin
              state_q <= parity_en_i ? RX_PARITY : RX_STOP;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        RX_PARITY: begin
          if (bit_done) begin
            perr_q  <= rx_s ^ parity_q;  // even parity check
            state_q <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (bit_done) state_q <= RX_HOLD;  // mid stop bit
        end
        RX_HOLD: begin
          if (rx_ready_i) state_q <= RX_IDLE;  // stalls while fifo full
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/uart_interrupt.sv */
// UART interrupt identification
`timescale 1ns/1ps
`default_nettype none

module uart_interrupt import uart_reg_pkg::*, uart_line_pkg::*; (
  input  logic       CLK,
  input  logic       RSTN,
  input  logic [2:0] ier_i,          // RLS, THRE, RDA enables
  input  logic       parity_err_i,   // head entry flag
  input  rx_count_t  rx_elements_i,
  input  tx_count_t  tx_elements_i,
  input  trig_t      trig_i,
  input  logic       iir_read_i,     // one-cycle pulses from the bus
  input  logic       thr_write_i,
  output logic       event_o,
  output logic [3:0] iir_o
);

  rx_count_t  trig_level;
  logic       tx_empty;
  logic       tx_empty_q;
  logic       thre_flag_q;  // sticky until IIR read or THR write
  logic       rls_act;
  logic       rda_act;
  logic       thre_act;
  logic [3:0] iir_next;

  always_comb begin
    case (trig_i)
      2'd0:    trig_level = rx_count_t'(1);
      2'd1:    trig_level = rx_count_t'(4);
      2'd2:    trig_level = rx_count_t'(8);
      default: trig_level = rx_count_t'(14);
    endcase
  end

  assign tx_empty = (tx_elements_i == '0);
  assign rls_act  = ier_i[2] & parity_err_i;
  assign rda_act  = ier_i[0] & (rx_elements_i >= trig_level);
  assign thre_act = ier_i[1] & thre_flag_q;

  // fixed priority, line status first
  always_comb begin
    if (rls_act)       iir_next = IIR_RLS;
    else if (rda_act)  iir_next = IIR_RDA;
    else if (thre_act) iir_next = IIR_THRE;
    else               iir_next = IIR_NONE;
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      tx_empty_q  <= 1'b1;
      thre_flag_q <= 1'b0;
      event_o     <= 1'b0;
      iir_o       <= IIR_NONE;
    end else begin
      tx_empty_q <= tx_empty;
      if (tx_empty && !tx_empty_q) begin
        thre_flag_q <= 1'b1;  // fifo just drained
      end else if (iir_read_i || thr_write_i) begin
        thre_flag_q <= 1'b0;
      end
      event_o <= rls_act | rda_act | thre_act;
      iir_o   <= iir_next;
    end
  end

endmodule

`default_nettype wire

/* design/apb_uart.sv */
// APB UART register block
`timescale 1ns/1ps
`default_nettype none

module apb_uart import uart_reg_pkg::*, uart_line_pkg::*; (
  input  logic                      CLK,
  input  logic                      RSTN,
  input  logic [APB_ADDR_WIDTH-1:0] PADDR_i,
  input  logic [APB_DATA_WIDTH-1:0] PWDATA_i,
  input  logic                      PWRITE_i,
  input  logic                      PSEL_i,
  input  logic                      PENABLE_i,
  output logic [APB_DATA_WIDTH-1:0] PRDATA_o,
  output logic                      PREADY_o,
  output logic                      PSLVERR_o,
  input  logic                      rx_i,
  output logic                      tx_o,
  output logic                      event_o
);

  logic [2:0]    reg_addr;
  logic          wr_en;          // access phase write
  logic          rd_en;
  logic          dlab;           // LCR[7]
  logic [7:0]    ier_q;
  logic [7:0]    lcr_q;
  logic [7:0]    scr_q;
  logic [7:0]    dll_q;
  logic [7:0]    dlm_q;
  trig_t         trig_q;
  logic          rx_clr_q;       // FCR clears, one cycle after the write
  logic          tx_clr_q;
  logic          thr_write;
  logic          rbr_read;
  logic          iir_read;
  logic          tx_fifo_ready;
  uart_byte_t    tx_data;
  logic          tx_valid;
  logic          tx_ready;       // transmitter idle
  tx_count_t     tx_elements;
  uart_rx_word_t rx_word;
  logic          rx_valid;
  logic          rx_ready;
  uart_rx_word_t rx_head;
  logic          rx_head_valid;
  rx_count_t     rx_elements;
  logic          head_perr;
  logic [7:0]    lsr;
  logic [7:0]    rdata;
  logic [3:0]    iir;

  assign reg_addr  = PADDR_i[2:0];
  assign wr_en     = PSEL_i & PENABLE_i & PWRITE_i;
  assign rd_en     = PSEL_i & PENABLE_i & ~PWRITE_i;
  assign dlab      = lcr_q[7];
  assign thr_write = wr_en & (reg_addr == REG_RBR_THR_DLL) & ~dlab;
  assign rbr_read  = rd_en & (reg_addr == REG_RBR_THR_DLL) & ~dlab;  // pops rx fifo
  assign iir_read  = rd_en & (reg_addr == REG_IIR_FCR);
  assign head_perr = rx_head_valid & rx_head.parity_err;

  ////////////////////////////////////////////////////////////////////////////
  // register writes
  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      ier_q    <= '0;
      lcr_q    <= '0;
      scr_q    <= '0;
      dll_q    <= '0;
      dlm_q    <= '0;
      trig_q   <= '0;
      rx_clr_q <= 1'b0;
      tx_clr_q <= 1'b0;
    end else begin
      rx_clr_q <= 1'b0;  // self clearing
      tx_clr_q <= 1'b0;
      if (wr_en) begin
        case (reg_addr)
          REG_RBR_THR_DLL: if (dlab) dll_q <= PWDATA_i[7:0];  // THR goes to the fifo
          REG_IER_DLM: begin
            if (dlab) dlm_q <= PWDATA_i[7:0];
            else      ier_q <= PWDATA_i[7:0];
          end
          REG_IIR_FCR: begin
            rx_clr_q <= PWDATA_i[1];
            tx_clr_q <= PWDATA_i[2];
            trig_q   <= PWDATA_i[7:6];
          end
          REG_LCR: lcr_q <= PWDATA_i[7:0];
          REG_SCR: scr_q <= PWDATA_i[7:0];
          default: ;
        endcase
      end
    end
  end

  // live line status
  always_comb begin
    lsr           = '0;
    lsr[LSR_DR]   = rx_head_valid;
    lsr[LSR_PE]   = head_perr;
    lsr[LSR_THRE] = (tx_elements == '0);
    lsr[LSR_TEMT] = (tx_elements == '0) & tx_ready;
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux, zero-extended
  always_comb begin
    case (reg_addr)
      REG_RBR_THR_DLL: rdata = dlab ? dll_q : rx_head.data;
      REG_IER_DLM:     rdata = dlab ? dlm_q : ier_q;
      REG_IIR_FCR:     rdata = {4'hC, iir};  // fifo enabled bits always set
      REG_LCR:         rdata = lcr_q;
      REG_LSR:         rdata = lsr;
      REG_SCR:         rdata = scr_q;
      default:         rdata = 8'h00;         // no modem regs
    endcase
  end

  assign PRDATA_o  = {{(APB_DATA_WIDTH - 8){1'b0}}, rdata};
  assign PREADY_o  = 1'b1;  // zero wait states
  assign PSLVERR_o = 1'b0;

  ////////////////////////////////////////////////////////////////////////////
  // datapath blocks
  uart_fifo #(.DEPTH(TX_FIFO_DEPTH), .payload_t(uart_byte_t)) u_tx_fifo (
    .CLK        (CLK),
    .RSTN       (RSTN),
    .clr_i      (tx_clr_q),
    .valid_i    (thr_write & tx_fifo_ready),  // full fifo drops the byte
    .data_i     (PWDATA_i[7:0]),
    .ready_o    (tx_fifo_ready),
    .data_o     (tx_data),
    .valid_o    (tx_valid),
    .ready_i    (tx_ready),
    .elements_o (tx_elements)
  );

  uart_tx u_tx (
    .CLK         (CLK),
    .RSTN        (RSTN),
    .div_i       ({dlm_q, dll_q}),
    .char_len_i  (lcr_q[1:0]),
    .parity_en_i (lcr_q[3]),
    .two_stop_i  (lcr_q[2]),
    .data_i      (tx_data),
    .valid_i     (tx_valid),
    .ready_o     (tx_ready),
    .tx_o        (tx_o)
  );

  uart_rx u_rx (
    .CLK         (CLK),
    .RSTN        (RSTN),
    .rx_i        (rx_i),
    .div_i       ({dlm_q, dll_q}),
    .char_len_i  (lcr_q[1:0]),
    .parity_en_i (lcr_q[3]),
    .rx_word_o   (rx_word),
    .rx_valid_o  (rx_valid),
    .rx_ready_i  (rx_ready)
  );

  uart_fifo #(.DEPTH(RX_FIFO_DEPTH), .payload_t(uart_rx_word_t)) u_rx_fifo (
    .CLK        (CLK),
    .RSTN       (RSTN),
    .clr_i      (rx_clr_q),
    .valid_i    (rx_valid),
    .data_i     (rx_word),
    .ready_o    (rx_ready),
    .data_o     (rx_head),
    .valid_o    (rx_head_valid),
    .ready_i    (rbr_read),
    .elements_o (rx_elements)
  );

  uart_interrupt u_irq (
    .CLK           (CLK),
    .RSTN          (RSTN),
    .ier_i         (ier_q[2:0]),
    .parity_err_i  (head_perr),
    .rx_elements_i (rx_elements),
    .tx_elements_i (tx_elements),
    .trig_i        (trig_q),
    .iir_read_i    (iir_read),
    .thr_write_i   (thr_write),
    .event_o       (event_o),
    .iir_o         (iir)
  );

endmodule

`default_nettype wire

/* verification/apb_uart_sva.sv */
// APB UART assertions
`timescale 1ns/1ps
`default_nettype none

module apb_uart_sva import uart_line_pkg::*; (
  input logic       CLK,
  input logic       RSTN,
  input logic       pready_i,
  input logic       pslverr_i,
  input logic       tx_line_i,
  input logic       event_i,
  input logic [7:0] ier_i,
  input tx_count_t  tx_elements_i,
  input logic       tx_idle_i      // transmitter FSM in idle
);

  // zero wait states, never an error response
  a_pready: assert property (@(posedge CLK) disable iff (!RSTN) pready_i)
    else $error("PREADY low");
  a_pslverr: assert property (@(posedge CLK) disable iff (!RSTN) !pslverr_i)
    else $error("PSLVERR high");

  // empty fifo and idle shifter keep the line at mark
  a_tx_idle: assert property (@(posedge CLK) disable iff (!RSTN)
    (tx_elements_i == '0 && tx_idle_i) |=> tx_line_i)
    else $error("tx line low while transmitter idle");

  // event_o is registered, so it follows the enables one cycle later
  a_no_event: assert property (@(posedge CLK) disable iff (!RSTN)
    (ier_i[2:0] == 3'b000) |=> !event_i)
    else $error("event_o high with all interrupts disabled");

endmodule

bind apb_uart apb_uart_sva u_sva (
  .CLK           (CLK),
  .RSTN          (RSTN),
  .pready_i      (PREADY_o),
  .pslverr_i     (PSLVERR_o),
  .tx_line_i     (tx_o),
  .event_i       (event_o),
  .ier_i         (ier_q),
  .tx_elements_i (tx_elements),
  .tx_idle_i     (tx_ready)
);

`default_nettype wire

/* verification/apb_uart_tb.sv */
// APB UART testbench
`timescale 1ns/1ps
`default_nettype none

module apb_uart_tb import uart_reg_pkg::*, uart_line_pkg::*;;

  localparam int BIT_CLKS   = 8;     // divisor 7
  localparam int POLL_LIMIT = 1000;  // LSR reads before giving up

  logic                      CLK;
  logic                      RSTN;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic [APB_DATA_WIDTH-1:0] pwdata;
  logic [APB_DATA_WIDTH-1:0] prdata;
  logic                      pwrite;
  logic                      psel;
  logic                      penable;
  logic                      pready;
  logic                      pslverr;
  logic                      rx_line;
  logic                      tx_line;
  logic                      event_line;
  logic                      bad_active;   // bad-frame driver owns the line
  logic                      bad_level;

  // register model
  uart_byte_t mdl_ier;
  uart_byte_t mdl_lcr;
  uart_byte_t mdl_scr;
  uart_byte_t mdl_dll;
  uart_byte_t mdl_dlm;
  trig_t      mdl_trig;
  uart_byte_t exp_q[$];   // characters in flight, oldest first
  uart_byte_t got_q[$];   // RBR reads waiting for compare
  int         mismatches;
  int         failures;
  integer     seed;

  assign rx_line = bad_active ? bad_level : tx_line;  // loopback by default

  apb_uart u_dut (
    .CLK       (CLK),
    .RSTN      (RSTN),
    .PADDR_i   (paddr),
    .PWDATA_i  (pwdata),
    .PWRITE_i  (pwrite),
    .PSEL_i    (psel),
    .PENABLE_i (penable),
    .PRDATA_o  (prdata),
    .PREADY_o  (pready),
    .PSLVERR_o (pslverr),
    .rx_i      (rx_line),
    .tx_o      (tx_line),
    .event_o   (event_line)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  function automatic uart_byte_t expected_reg(logic [2:0] off);
    case (off)
      REG_RBR_THR_DLL: return mdl_lcr[7] ? mdl_dll : 8'h00;
      REG_IER_DLM:     return mdl_lcr[7] ? mdl_dlm : mdl_ier;
      REG_LCR:         return mdl_lcr;
      REG_SCR:         return mdl_scr;
      default:         return 8'h00;  // modem offsets
    endcase
  endfunction

  function automatic uart_byte_t expected_lsr(logic dr, logic pe, logic thre, logic temt);
    uart_byte_t v;
    v = '0;
    v[LSR_DR]   = dr;
    v[LSR_PE]   = pe;
    v[LSR_THRE] = thre;
    v[LSR_TEMT] = temt;
    return v;
  endfunction

  // highest pending source, line status first
  function automatic logic [3:0] expected_iir(logic [2:0] ier, logic perr, int rx_cnt,
                                              logic thre_pend);
    int level;
    case (mdl_trig)
      2'd0:    level = 1;
      2'd1:    level = 4;
      2'd2:    level = 8;
      default: level = 14;
    endcase
    if (ier[2] && perr) return IIR_RLS;
    if (ier[0] && rx_cnt >= level) return IIR_RDA;
    if (ier[1] && thre_pend) return IIR_THRE;
    return IIR_NONE;
  endfunction

  function automatic uart_byte_t char_mask(uart_byte_t b, char_len_t len);
    return b & (8'hFF >> (3 - len));  // 5..8 data bits
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  task automatic check_byte(string name, uart_byte_t got, uart_byte_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got 0x%02h, expected 0x%02h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_iir(string name, logic [3:0] got, logic [3:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b, expected %b", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b, expected %b", $time, name, got, exp);
      mismatches++;
    end
  endtask

  // access phase response, no wait states and no slave error
  task automatic check_resp();
    check_flag("PREADY", pready, 1'b1);
    check_flag("PSLVERR", pslverr, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB access, one idle cycle after each transfer
  task automatic model_write(logic [2:0] off, uart_byte_t data);
    case (off)
      REG_RBR_THR_DLL: begin
        if (mdl_lcr[7]) mdl_dll = data;
        else exp_q.push_back(char_mask(data, mdl_lcr[1:0]));  // THR
      end
      REG_IER_DLM: begin
        if (mdl_lcr[7]) mdl_dlm = data;
        else mdl_ier = data;
      end
      REG_IIR_FCR: begin
        mdl_trig = data[7:6];
        if (data[1]) exp_q.delete();  // rx fifo flushed
      end
      REG_LCR: mdl_lcr = data;
      REG_SCR: mdl_scr = data;
      default: ;
    endcase
  endtask

  task automatic apb_write(logic [2:0] off, uart_byte_t data);
    @(negedge CLK);
    psel    = 1'b1;                       // setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = APB_ADDR_WIDTH'(off);
    pwdata  = APB_DATA_WIDTH'(data);
    @(negedge CLK);
    penable = 1'b1;                       // access, takes effect next posedge
    #1;
    check_resp();
    @(negedge CLK);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    model_write(off, data);
  endtask

  task automatic apb_read(logic [2:0] off, output uart_byte_t data);
    @(negedge CLK);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = APB_ADDR_WIDTH'(off);
    @(negedge CLK);
    penable = 1'b1;
    #1;                                   // PRDATA settled, before the edge
    data = prdata[7:0];
    check_resp();
    if (prdata[APB_DATA_WIDTH-1:8] !== '0) begin
      $display("ERROR at %0t ns: PRDATA upper bits are not zero", $time);
      failures++;
    end
    if (off == REG_RBR_THR_DLL && !mdl_lcr[7]) got_q.push_back(data);
    @(negedge CLK);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_reg_check(logic [2:0] off, string name);
    uart_byte_t rd;
    apb_read(off, rd);
    check_byte(name, rd, expected_reg(off));
  endtask

  task automatic read_lsr_check(logic dr, logic pe, logic thre, logic temt);
    uart_byte_t rd;
    apb_read(REG_LSR, rd);
    check_byte("LSR", rd, expected_lsr(dr, pe, thre, temt));
  endtask

  task automatic read_iir_check(logic perr, int rx_cnt, logic thre_pend);
    uart_byte_t rd;
    apb_read(REG_IIR_FCR, rd);
    check_iir("IIR[7:4]", rd[7:4], 4'hC);
    check_iir("IIR", rd[3:0], expected_iir(mdl_ier[2:0], perr, rx_cnt, thre_pend));
  endtask

  // poll LSR until a bit is set
  task automatic wait_lsr(int bit_pos, string what);
    uart_byte_t lsr;
    int         polls;
    lsr   = '0;
    polls = 0;
    while (!lsr[bit_pos] && polls < POLL_LIMIT) begin
      apb_read(REG_LSR, lsr);
      polls++;
    end
    if (!lsr[bit_pos]) begin
      $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
      failures++;
    end
  endtask

  // random bytes out through tx, back in through rx
  task automatic send_bytes(int n);
    for (int i = 0; i < n; i++) apb_write(REG_RBR_THR_DLL, uart_byte_t'($random(seed)));
    wait_lsr(LSR_TEMT, "TEMT");
    wait_lsr(LSR_DR, "DR");             // last stop bit sampled by now
  endtask

  task automatic drain_rx(int n);
    uart_byte_t rd;
    for (int i = 0; i < n; i++) begin
      wait_lsr(LSR_DR, "DR");
      apb_read(REG_RBR_THR_DLL, rd);
    end
  endtask

  // 8 data bits, parity bit inverted
  task automatic send_bad_frame(uart_byte_t data);
    logic [10:0] frame;
    frame = {1'b1, ~(^data), data, 1'b0};  // stop, parity, data, start
    @(negedge CLK);
    bad_level  = 1'b1;
    bad_active = 1'b1;
    for (int i = 0; i < 11; i++) begin
      bad_level = frame[i];
      repeat (BIT_CLKS) @(negedge CLK);
    end
    bad_active = 1'b0;                     // back to loopback, line high
    exp_q.push_back(data);
  endtask

  // every RBR read against the oldest character in flight
  always @(posedge CLK) begin : compare_rbr
    uart_byte_t got_b;
    while (got_q.size() != 0) begin
      got_b = got_q.pop_front();
      if (exp_q.size() == 0) begin
        $display("ERROR at %0t ns: RBR returned 0x%02h with nothing sent", $time, got_b);
        failures++;
      end else begin
        check_byte("RBR", got_b, exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  initial begin : stimulus
    uart_byte_t v;
    int         n;
    seed       = 21;
    mismatches = 0;
    failures   = 0;
    RSTN       = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    pwrite     = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    bad_active = 1'b0;
    bad_level  = 1'b1;
    mdl_ier    = '0;
    mdl_lcr    = '0;
    mdl_scr    = '0;
    mdl_dll    = '0;
    mdl_dlm    = '0;
    mdl_trig   = '0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RSTN = 1'b1;

    // reset values, scratch register
    read_lsr_check(1'b0, 1'b0, 1'b1, 1'b1);
    read_iir_check(1'b0, 0, 1'b0);
    read_reg_check(REG_IER_DLM, "IER");
    read_reg_check(REG_LCR, "LCR");
    read_reg_check(3'd4, "MCR");
    read_reg_check(3'd6, "MSR");
    for (int i = 0; i < 4; i++) begin
      apb_write(REG_SCR, uart_byte_t'($random(seed)));
      read_reg_check(REG_SCR, "SCR");
    end

    // divisor latch behind DLAB
    apb_write(REG_LCR, 8'h80);
    apb_write(REG_RBR_THR_DLL, 8'h5A);
    apb_write(REG_IER_DLM, 8'hA5);
    read_reg_check(REG_RBR_THR_DLL, "DLL");
    read_reg_check(REG_IER_DLM, "DLM");
    read_lsr_check(1'b0, 1'b0, 1'b1, 1'b1);  // offset 0 pushed nothing
    check_flag("tx_o", tx_line, 1'b1);
    apb_write(REG_RBR_THR_DLL, 8'(BIT_CLKS - 1));
    apb_write(REG_IER_DLM, 8'h00);
    apb_write(REG_LCR, 8'h03);

    // loopback over lengths and parity, two stop bits on odd codes
    for (int clen = 0; clen < 4; clen++) begin
      for (int par = 0; par < 2; par++) begin
        apb_write(REG_LCR, {4'b0000, par[0], clen[0], clen[1:0]});
        n = 1 + ($random(seed) & 15);
        for (int i = 0; i < n; i++) apb_write(REG_RBR_THR_DLL, uart_byte_t'($random(seed)));
        drain_rx(n);
        wait_lsr(LSR_TEMT, "TEMT");
        read_lsr_check(1'b0, 1'b0, 1'b1, 1'b1);
      end
    end

    // wrong parity flagged on the head entry
    apb_write(REG_LCR, 8'h0B);              // 8 bits, even parity
    apb_write(REG_IER_DLM, 8'h04);
    v = uart_byte_t'($random(seed));
    send_bad_frame(v);
    wait_lsr(LSR_DR, "DR after bad frame");
    read_lsr_check(1'b1, 1'b1, 1'b1, 1'b1);
    read_iir_check(1'b1, 1, 1'b0);
    drain_rx(1);
    read_lsr_check(1'b0, 1'b0, 1'b1, 1'b1);

    // rx data available at trigger level 4
    apb_write(REG_LCR, 8'h03);
    apb_write(REG_IIR_FCR, 8'h40);
    apb_write(REG_IER_DLM, 8'h01);
    send_bytes(3);
    check_flag("event_o", event_line, expected_iir(mdl_ier[2:0], 1'b0, 3, 1'b1) != IIR_NONE);
    read_iir_check(1'b0, 3, 1'b1);
    send_bytes(1);
    check_flag("event_o", event_line, expected_iir(mdl_ier[2:0], 1'b0, 4, 1'b1) != IIR_NONE);
    read_iir_check(1'b0, 4, 1'b1);
    drain_rx(4);
    read_iir_check(1'b0, 0, 1'b0);
    check_flag("event_o", event_line, 1'b0);

    // THRE sets on drain, IIR read clears it
    apb_write(REG_IER_DLM, 8'h02);
    send_bytes(1);
    check_flag("event_o", event_line, expected_iir(mdl_ier[2:0], 1'b0, 1, 1'b1) != IIR_NONE);
    read_iir_check(1'b0, 1, 1'b1);
    read_iir_check(1'b0, 1, 1'b0);
    check_flag("event_o", event_line, 1'b0);
    drain_rx(1);
    apb_write(REG_IER_DLM, 8'h00);

    // FCR rx flush
    send_bytes(3);
    read_lsr_check(1'b1, 1'b0, 1'b1, 1'b1);
    apb_write(REG_IIR_FCR, 8'h42);
    read_lsr_check(1'b0, 1'b0, 1'b1, 1'b1);

    repeat (4) @(posedge CLK);             // let the compare process catch up
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d characters were sent but never read back", exp_q.size());
      failures++;
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* apb_uart.f */
design/uart_reg_pkg.sv
design/uart_line_pkg.sv
design/uart_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_interrupt.sv
design/apb_uart.sv
verification/apb_uart_sva.sv
verification/apb_uart_tb.sv
